/* hdl/kbd_bus_pkg.sv */
// shared widths, line constants and state encodings for the keyboard unit line bus
package kbd_bus_pkg;

   // bus and line address, low 4 bits are the byte offset
   typedef logic [15:0]  addr_t;

   // one data beat on the bus
   typedef logic [31:0]  beat_t;

   // one 16-byte line, beat 0 sits in bits 31:0
   typedef logic [127:0] line_t;

   // byte count carried on the size lines
   typedef logic [11:0]  size_t;

   // every transfer moves a whole line
   localparam size_t LINE_BYTES = 12'd16;
   localparam size_t BEAT_BYTES = 12'd4;

   // controller FSM
   typedef enum logic [2:0] {
      IDLE,
      ST_BR,
      MSTR,
      ST_WR,
      SLV,
      ST_RD
   } ctrl_state_e;

   // memory FSM, idle gets its own name so it does not clash with the controller
   typedef enum logic [2:0] {
      MEM_IDLE,
      WR_BEATS,
      LAT_WAIT,
      RD_BR,
      RD_MSTR,
      RD_BEATS
   } slave_state_e;

endpackage

/* hdl/kbd_bus_controller.sv */
// keyboard unit bus controller, turns work unit line requests into bus transactions
module kbd_bus_controller (
   input  logic               bus_clk,
   input  logic               rst_n,
   // arbiter handshake
   output logic               br,
   input  logic               bg,
   // direct wires to and from the memory
   output logic               ack_out,
   input  logic               ack_in,
   output logic               dest_out,
   input  logic               dest_in,
   // outputs go through the arbiter mux, d_in is the shared data bus
   output kbd_bus_pkg::addr_t a_out,
   output kbd_bus_pkg::beat_t d_out,
   input  kbd_bus_pkg::beat_t d_in,
   output kbd_bus_pkg::size_t size_out,
   output logic               rw_out,
   // work unit side
   input  logic               mod_en,
   input  logic               mod_wr,
   input  kbd_bus_pkg::addr_t mod_a,
   input  kbd_bus_pkg::line_t mod_write_data,
   output kbd_bus_pkg::line_t mod_read_data,
   output logic               mod_r
);

   kbd_bus_pkg::ctrl_state_e state_q;
   kbd_bus_pkg::ctrl_state_e state_d;
   kbd_bus_pkg::size_t       size_q;
   kbd_bus_pkg::size_t       size_nxt;
   kbd_bus_pkg::line_t       rd_line_q;
   logic [1:0]               slot;
   logic                     req_mask_q;
   logic                     masked_en;
   logic                     start;
   logic                     beat_en;
   logic                     done;
   logic                     ready_q;

   // held mod_en only counts once per request
   assign masked_en = mod_en && !req_mask_q;
   assign start     = (state_q == kbd_bus_pkg::IDLE) && masked_en;

   // size counter steps down one beat per data cycle
   assign beat_en  = (state_q == kbd_bus_pkg::ST_WR) || (state_q == kbd_bus_pkg::ST_RD);
   assign size_nxt = size_q - kbd_bus_pkg::BEAT_BYTES;
   // as size goes down the slot goes up, 12 -> beat 0 ... 0 -> beat 3
   assign slot     = ~size_nxt[3:2];
   assign done     = beat_en && (size_nxt == '0);

   always_comb begin
      state_d = state_q;
      case (state_q)
         kbd_bus_pkg::IDLE: begin
            if (masked_en) begin
               state_d = kbd_bus_pkg::ST_BR;
            end
         end
         kbd_bus_pkg::ST_BR: begin
            if (bg) begin
               state_d = kbd_bus_pkg::MSTR;
            end
         end
         // hold the address phase until the memory takes it
         kbd_bus_pkg::MSTR: begin
            if (ack_in) begin
               state_d = mod_wr ? kbd_bus_pkg::ST_WR : kbd_bus_pkg::SLV;
            end
         end
         kbd_bus_pkg::SLV: begin
            if (dest_in) begin
               state_d = kbd_bus_pkg::ST_RD;
            end
         end
         kbd_bus_pkg::ST_WR,
         kbd_bus_pkg::ST_RD: begin
            if (done) begin
               state_d = kbd_bus_pkg::IDLE;
            end
         end
         default: state_d = kbd_bus_pkg::IDLE;
      endcase
   end

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q    <= kbd_bus_pkg::IDLE;
         size_q     <= kbd_bus_pkg::LINE_BYTES;
         req_mask_q <= 1'b0;
         ready_q    <= 1'b0;
      end else begin
         state_q <= state_d;
         // reload to a full line whenever no beats are moving
         size_q  <= beat_en ? size_nxt : kbd_bus_pkg::LINE_BYTES;
         // mask is set on start and only cleared by a low mod_en
         if (start) begin
            req_mask_q <= 1'b1;
         end else if (!mod_en) begin
            req_mask_q <= 1'b0;
         end
         ready_q <= done;
      end
   end

   // read line buffer, one slot per returned beat
   always_ff @(posedge bus_clk) begin
      if (state_q == kbd_bus_pkg::ST_RD) begin
         rd_line_q[{slot, 5'b0} +: 32] <= d_in;
      end
   end

   assign mod_read_data = rd_line_q;
   assign mod_r         = ready_q;

   // bus request covers arbitration, address phase and write beats
   assign br       = (state_q == kbd_bus_pkg::ST_BR) || (state_q == kbd_bus_pkg::MSTR) ||
                     (state_q == kbd_bus_pkg::ST_WR);
   // destination line always points at memory
   assign dest_out = (state_q == kbd_bus_pkg::MSTR);
   // answer memory on the first cycle it addresses us
   assign ack_out  = (state_q == kbd_bus_pkg::SLV) && dest_in;

   assign a_out    = dest_out ? mod_a : '0;
   assign size_out = dest_out ? kbd_bus_pkg::LINE_BYTES : '0;
   assign rw_out   = dest_out && mod_wr;
   assign d_out    = (state_q == kbd_bus_pkg::ST_WR) ? mod_write_data[{slot, 5'b0} +: 32] : '0;

endmodule

/* hdl/bus_arbiter.sv */
// two-client bus arbiter with registered grant, also forms the shared bus from the owner
module bus_arbiter (
   input  logic               bus_clk,
   input  logic               rst_n,
   // client 0 is the controller, client 1 the memory
   input  logic               br_ctrl,
   input  logic               br_mem,
   output logic               bg_ctrl,
   output logic               bg_mem,
   input  kbd_bus_pkg::addr_t a_ctrl,
   input  kbd_bus_pkg::addr_t a_mem,
   input  kbd_bus_pkg::beat_t d_ctrl,
   input  kbd_bus_pkg::beat_t d_mem,
   input  kbd_bus_pkg::size_t size_ctrl,
   input  kbd_bus_pkg::size_t size_mem,
   input  logic               rw_ctrl,
   input  logic               rw_mem,
   // shared bus seen by both clients
   output kbd_bus_pkg::addr_t a,
   output kbd_bus_pkg::beat_t d,
   output kbd_bus_pkg::size_t size,
   output logic               rw
);

   logic hold_ctrl;
   logic hold_mem;

   // owner keeps the bus while its request stays up
   assign hold_ctrl = bg_ctrl && br_ctrl;
   assign hold_mem  = bg_mem && br_mem;

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         bg_ctrl <= 1'b0;
         bg_mem  <= 1'b0;
      end else if (hold_ctrl || hold_mem) begin
         bg_ctrl <= hold_ctrl;
         bg_mem  <= hold_mem;
      end else begin
         // bus is free, memory wins a tie so read returns always get through
         bg_mem  <= br_mem;
         bg_ctrl <= br_ctrl && !br_mem;
      end
   end

   // no owner drives zeros
   always_comb begin
      a    = '0;
      d    = '0;
      size = '0;
      rw   = 1'b0;
      if (bg_ctrl) begin
         a    = a_ctrl;
         d    = d_ctrl;
         size = size_ctrl;
         rw   = rw_ctrl;
      end else if (bg_mem) begin
         a    = a_mem;
         d    = d_mem;
         size = size_mem;
         rw   = rw_mem;
      end
   end

endmodule

/* hdl/ram_bus_slave.sv */
// line memory on the bus, takes write lines and returns read lines as master after a latency
module ram_bus_slave #(
   parameter int MEM_LINES_LOG = 6,
   parameter int MEM_LAT       = 3
) (
   input  logic               bus_clk,
   input  logic               rst_n,
   // arbiter handshake for the read return
   output logic               br,
   input  logic               bg,
   // direct wires to and from the controller
   output logic               ack_out,
   input  logic               ack_in,
   output logic               dest_out,
   input  logic               dest_in,
   // shared bus inputs
   input  kbd_bus_pkg::addr_t a,
   input  logic               rw,
   input  kbd_bus_pkg::beat_t d_in,
   // outputs go through the arbiter mux
   output kbd_bus_pkg::addr_t a_out,
   output kbd_bus_pkg::beat_t d_out,
   output kbd_bus_pkg::size_t size_out,
   output logic               rw_out
);

   // latency counter wide enough for MEM_LAT-1
   localparam int LAT_W = (MEM_LAT > 1) ? $clog2(MEM_LAT) : 1;

   kbd_bus_pkg::slave_state_e state_q;
   kbd_bus_pkg::slave_state_e state_d;
   kbd_bus_pkg::line_t        mem [2**MEM_LINES_LOG];
   kbd_bus_pkg::line_t        line_q;
   kbd_bus_pkg::addr_t        addr_q;
   logic [MEM_LINES_LOG-1:0]  line_idx;
   logic [1:0]                beat_q;
   logic [LAT_W-1:0]          lat_q;
   logic                      take;
   logic                      last_beat;
   logic                      lat_done;

   // line index starts above the byte offset, higher bits alias
   assign line_idx  = addr_q[4 +: MEM_LINES_LOG];
   // only idle accepts, so a pending read holds off any new address phase
   assign take      = (state_q == kbd_bus_pkg::MEM_IDLE) && dest_in;
   assign last_beat = (beat_q == 2'd3);
   assign lat_done  = (state_q == kbd_bus_pkg::LAT_WAIT) && (lat_q == '0);

   always_comb begin
      state_d = state_q;
      case (state_q)
         kbd_bus_pkg::MEM_IDLE: begin
            if (take) begin
               state_d = rw ? kbd_bus_pkg::WR_BEATS : kbd_bus_pkg::LAT_WAIT;
            end
         end
         kbd_bus_pkg::LAT_WAIT: begin
            if (lat_done) begin
               state_d = kbd_bus_pkg::RD_BR;
            end
         end
         kbd_bus_pkg::RD_BR: begin
            if (bg) begin
               state_d = kbd_bus_pkg::RD_MSTR;
            end
         end
         kbd_bus_pkg::RD_MSTR: begin
            if (ack_in) begin
               state_d = kbd_bus_pkg::RD_BEATS;
            end
         end
         kbd_bus_pkg::WR_BEATS,
         kbd_bus_pkg::RD_BEATS: begin
            if (last_beat) begin
               state_d = kbd_bus_pkg::MEM_IDLE;
            end
         end
         default: state_d = kbd_bus_pkg::MEM_IDLE;
      endcase
   end

   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= kbd_bus_pkg::MEM_IDLE;
         beat_q  <= 2'd0;
         lat_q   <= '0;
      end else begin
         state_q <= state_d;
         // beat index wraps back to 0 after the fourth beat
         if (state_q == kbd_bus_pkg::WR_BEATS || state_q == kbd_bus_pkg::RD_BEATS) begin
            beat_q <= beat_q + 2'd1;
         end
         if (take) begin
            lat_q <= LAT_W'(MEM_LAT - 1);
         end else if (state_q == kbd_bus_pkg::LAT_WAIT) begin
            lat_q <= lat_q - 1'b1;
         end
      end
   end

   // line array starts out all zero
   always_ff @(posedge bus_clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 2**MEM_LINES_LOG; i++) begin
            mem[i] <= '0;
         end
      end else if (state_q == kbd_bus_pkg::WR_BEATS && last_beat) begin
         // fourth beat goes straight in with the three already assembled
         mem[line_idx] <= {d_in, line_q[95:0]};
      end
   end

   // address and line buffer, direction lives on in the state
   always_ff @(posedge bus_clk) begin
      if (take) begin
         addr_q <= a;
      end
      if (state_q == kbd_bus_pkg::WR_BEATS) begin
         line_q[{beat_q, 5'b0} +: 32] <= d_in;
      end else if (lat_done) begin
         line_q <= mem[line_idx];
      end
   end

   assign ack_out  = take;
   assign br       = (state_q == kbd_bus_pkg::RD_BR) || (state_q == kbd_bus_pkg::RD_MSTR) ||
                     (state_q == kbd_bus_pkg::RD_BEATS);
   assign dest_out = (state_q == kbd_bus_pkg::RD_MSTR);

   // return phase writes the line into the controller
   assign a_out    = dest_out ? addr_q : '0;
   assign size_out = dest_out ? kbd_bus_pkg::LINE_BYTES : '0;
   assign rw_out   = dest_out;
   assign d_out    = (state_q == kbd_bus_pkg::RD_BEATS) ? line_q[{beat_q, 5'b0} +: 32] : '0;

endmodule

/* hdl/kbd_bus_top.sv */
// top level of the keyboard line bus, wires controller, arbiter and memory together
module kbd_bus_top #(
   parameter int MEM_LINES_LOG = 6,
   parameter int MEM_LAT       = 3
) (
   input  logic               bus_clk,
   input  logic               rst_n,
   input  logic               mod_en,
   input  logic               mod_wr,
   input  kbd_bus_pkg::addr_t mod_a,
   input  kbd_bus_pkg::line_t mod_write_data,
   output kbd_bus_pkg::line_t mod_read_data,
   output logic               mod_r
);

   // per-client request side
   logic               br_ctrl;
   logic               br_mem;
   logic               bg_ctrl;
   logic               bg_mem;
   logic               ack_ctrl;
   logic               ack_mem;
   logic               dest_ctrl;
   logic               dest_mem;
   kbd_bus_pkg::addr_t a_ctrl;
   kbd_bus_pkg::addr_t a_mem;
   kbd_bus_pkg::beat_t d_ctrl;
   kbd_bus_pkg::beat_t d_mem;
   kbd_bus_pkg::size_t size_ctrl;
   kbd_bus_pkg::size_t size_mem;
   logic               rw_ctrl;
   logic               rw_mem;

   // shared bus after the arbiter mux, no client here reads the size lines
   kbd_bus_pkg::addr_t bus_a;
   kbd_bus_pkg::beat_t bus_d;
   logic               bus_rw;

   kbd_bus_controller kbd_bus_controller_i (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .br             (br_ctrl),
      .bg             (bg_ctrl),
      .ack_out        (ack_ctrl),
      .ack_in         (ack_mem),
      .dest_out       (dest_ctrl),
      .dest_in        (dest_mem),
      .a_out          (a_ctrl),
      .d_out          (d_ctrl),
      .d_in           (bus_d),
      .size_out       (size_ctrl),
      .rw_out         (rw_ctrl),
      .mod_en         (mod_en),
      .mod_wr         (mod_wr),
      .mod_a          (mod_a),
      .mod_write_data (mod_write_data),
      .mod_read_data  (mod_read_data),
      .mod_r          (mod_r)
   );

   bus_arbiter bus_arbiter_i (
      .bus_clk   (bus_clk),
      .rst_n     (rst_n),
      .br_ctrl   (br_ctrl),
      .br_mem    (br_mem),
      .bg_ctrl   (bg_ctrl),
      .bg_mem    (bg_mem),
      .a_ctrl    (a_ctrl),
      .a_mem     (a_mem),
      .d_ctrl    (d_ctrl),
      .d_mem     (d_mem),
      .size_ctrl (size_ctrl),
      .size_mem  (size_mem),
      .rw_ctrl   (rw_ctrl),
      .rw_mem    (rw_mem),
      .a         (bus_a),
      .d         (bus_d),
      .size      (),
      .rw        (bus_rw)
   );

   // memory takes address, direction and data from the shared bus
   ram_bus_slave #(
      .MEM_LINES_LOG (MEM_LINES_LOG),
      .MEM_LAT       (MEM_LAT)
   ) ram_bus_slave_i (
      .bus_clk  (bus_clk),
      .rst_n    (rst_n),
      .br       (br_mem),
      .bg       (bg_mem),
      .ack_out  (ack_mem),
      .ack_in   (ack_ctrl),
      .dest_out (dest_mem),
      .dest_in  (dest_ctrl),
      .a        (bus_a),
      .rw       (bus_rw),
      .d_in     (bus_d),
      .a_out    (a_mem),
      .d_out    (d_mem),
      .size_out (size_mem),
      .rw_out   (rw_mem)
   );

endmodule

/* test/kbd_bus_tb.sv */
// testbench for the keyboard line bus, random work unit requests checked against a line model
module kbd_bus_tb;

   localparam int MEM_LINES_LOG  = 6;
   localparam int MEM_LAT        = 3;
   localparam int MEM_LINES      = 2**MEM_LINES_LOG;
   localparam int CLK_HALF       = 10;
   localparam int DRIVE_DLY      = 2;
   localparam int MIX_REQS       = 200;
   // requests over all tests: 1 + 8 + 4 + 2 + MIX_REQS
   localparam int NUM_REQS       = 15 + MIX_REQS;
   localparam int TIMEOUT_CYCLES = NUM_REQS * 40 + 100;

   logic               bus_clk;
   logic               rst_n;
   logic               mod_en;
   logic               mod_wr;
   kbd_bus_pkg::addr_t mod_a;
   kbd_bus_pkg::line_t mod_write_data;
   kbd_bus_pkg::line_t mod_read_data;
   logic               mod_r;

   // expected memory contents, indexed like the memory itself
   kbd_bus_pkg::line_t model [MEM_LINES];
   int                 cycle_cnt;

   kbd_bus_top #(
      .MEM_LINES_LOG (MEM_LINES_LOG),
      .MEM_LAT       (MEM_LAT)
   ) kbd_bus_top_i (
      .bus_clk        (bus_clk),
      .rst_n          (rst_n),
      .mod_en         (mod_en),
      .mod_wr         (mod_wr),
      .mod_a          (mod_a),
      .mod_write_data (mod_write_data),
      .mod_read_data  (mod_read_data),
      .mod_r          (mod_r)
   );

   initial begin
      bus_clk = 1'b0;
      forever #CLK_HALF bus_clk = ~bus_clk;
   end

   // hang guard, ends the run once the cycle budget is used up
   initial begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES) begin
         @(posedge bus_clk);
         cycle_cnt++;
      end
      $display("timeout, the run did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $fatal(1);
   end

   // line index sits above the 4 offset bits, higher bits alias
   function automatic int line_index(input kbd_bus_pkg::addr_t addr);
      return int'(addr[4 +: MEM_LINES_LOG]);
   endfunction

   function automatic kbd_bus_pkg::line_t rand_line();
      return {$urandom, $urandom, $urandom, $urandom};
   endfunction

   // random offset and alias bits around a chosen line index
   function automatic kbd_bus_pkg::addr_t make_addr(input int idx);
      kbd_bus_pkg::addr_t addr;
      addr = kbd_bus_pkg::addr_t'($urandom);
      addr[4 +: MEM_LINES_LOG] = idx[MEM_LINES_LOG-1:0];
      return addr;
   endfunction

   task automatic check_line(input string name, input kbd_bus_pkg::line_t expected,
                             input kbd_bus_pkg::line_t actual);
      if (actual !== expected) begin
         $display("ERROR %s expected %h actual %h", name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("ERROR %s expected %b actual %b", name, expected, actual);
         $display("ERRORS FOUND");
         $fatal(1);
      end
   endtask

   // one work unit request, returns the read line seen with mod_r
   task automatic run_request(input string name, input logic wr,
                              input kbd_bus_pkg::addr_t addr,
                              input kbd_bus_pkg::line_t wdata, input logic keep_en,
                              output kbd_bus_pkg::line_t rdata);
      @(posedge bus_clk);
      #DRIVE_DLY;
      mod_en         = 1'b1;
      mod_wr         = wr;
      mod_a          = addr;
      mod_write_data = wdata;
      // outputs sampled on the falling edge, well clear of the register updates
      @(negedge bus_clk);
      while (mod_r !== 1'b1) begin
         @(negedge bus_clk);
      end
      rdata = mod_read_data;
      if (!keep_en) begin
         @(posedge bus_clk);
         #DRIVE_DLY;
         mod_en = 1'b0;
      end
      // mod_r is a single cycle pulse
      @(negedge bus_clk);
      check_bit({name, " pulse end"}, 1'b0, mod_r);
   endtask

   task automatic write_line(input string name, input kbd_bus_pkg::addr_t addr,
                             input kbd_bus_pkg::line_t data);
      kbd_bus_pkg::line_t unused;
      run_request(name, 1'b1, addr, data, 1'b0, unused);
      model[line_index(addr)] = data;
   endtask

   task automatic read_line(input string name, input kbd_bus_pkg::addr_t addr);
      kbd_bus_pkg::line_t got;
      run_request(name, 1'b0, addr, '0, 1'b0, got);
      check_line(name, model[line_index(addr)], got);
   endtask

   initial begin
      kbd_bus_pkg::addr_t addr;
      kbd_bus_pkg::addr_t alias_base;
      kbd_bus_pkg::addr_t alias_lo;
      kbd_bus_pkg::addr_t alias_hi;
      kbd_bus_pkg::line_t data;
      kbd_bus_pkg::line_t got;

      rst_n          = 1'b0;
      mod_en         = 1'b0;
      mod_wr         = 1'b0;
      mod_a          = '0;
      mod_write_data = '0;
      void'($urandom(32'h6c94));
      for (int i = 0; i < MEM_LINES; i++) begin
         model[i] = '0;
      end

      repeat (5) @(posedge bus_clk);
      #DRIVE_DLY;
      rst_n = 1'b1;

      // no completion without a request
      repeat (10) begin
         @(negedge bus_clk);
         check_bit("idle after reset", 1'b0, mod_r);
      end

      // memory comes out of reset all zero
      run_request("unwritten read", 1'b0, 16'h03f0, '0, 1'b0, got);
      check_line("unwritten read", '0, got);

      // write then read back, beat order has to survive both directions
      for (int i = 0; i < 4; i++) begin
         addr = kbd_bus_pkg::addr_t'($urandom);
         data = rand_line();
         write_line($sformatf("roundtrip write %0d", i), addr, data);
         read_line($sformatf("roundtrip read %0d", i), addr);
      end

      // offset bits and bits above the index reach the same line
      alias_base = 16'h0120;
      alias_lo   = alias_base | 16'h000b;
      alias_hi   = alias_base | kbd_bus_pkg::addr_t'(1 << (4 + MEM_LINES_LOG));
      write_line("alias write base", alias_base, rand_line());
      read_line("alias read offset", alias_lo);
      write_line("alias write high", alias_hi, rand_line());
      read_line("alias read base", alias_base);

      // mod_en held across completion gives exactly one pulse
      addr = make_addr(5);
      data = rand_line();
      run_request("mask write", 1'b1, addr, data, 1'b1, got);
      model[line_index(addr)] = data;
      repeat (10) begin
         @(negedge bus_clk);
         check_bit("mask hold", 1'b0, mod_r);
      end
      @(posedge bus_clk);
      #DRIVE_DLY;
      mod_en = 1'b0;
      // one low cycle lets the next request through
      read_line("mask read", addr);

      // random mix over 8 lines with random gaps
      for (int i = 0; i < MIX_REQS; i++) begin
         addr = make_addr($urandom_range(7));
         if ($urandom_range(1) == 1) begin
            write_line($sformatf("mix write %0d", i), addr, rand_line());
         end else begin
            read_line($sformatf("mix read %0d", i), addr);
         end
         repeat ($urandom_range(3)) @(posedge bus_clk);
      end

      $display("NO ERRORS");
      $finish;
   end

endmodule

/* project.f */
hdl/kbd_bus_pkg.sv
hdl/kbd_bus_controller.sv
hdl/bus_arbiter.sv
hdl/ram_bus_slave.sv
hdl/kbd_bus_top.sv
test/kbd_bus_tb.sv
